// ==== arbitration/bank_lock_table.sv ====
module bank_lock_table (
    input  logic clk,
    input  logic reset,
    input  logic [output_bus_pkg::num_reqs-1:0] reqs,
    input  logic [output_bus_pkg::node_id_w-1:0] node_ids [output_bus_pkg::num_reqs],
    input  logic [output_bus_pkg::num_reqs-1:0] grants,
    input  logic [output_bus_pkg::num_writers-1:0] wr_eos,
    input  logic [output_bus_pkg::node_id_w-1:0] wr_node_id [output_bus_pkg::num_writers],
    input  logic [output_bus_pkg::num_banks-1:0] bank_eos,
    output logic [output_bus_pkg::num_reqs-1:0] masked_reqs
);

    logic [output_bus_pkg::num_banks-1:0] lock;
    logic [output_bus_pkg::num_banks-1:0] nx_lock;

    // bank each slot asked for in the arbitration cycle
    logic [output_bus_pkg::bank_w-1:0] target_bank [output_bus_pkg::num_reqs];

    always_comb begin
        logic [output_bus_pkg::bank_w-1:0] req_bank;
        logic [output_bus_pkg::bank_w-1:0] eos_bank;

        nx_lock = lock;

        // grant locks the bank registered with the request
        for (int i = 0; i < output_bus_pkg::num_reqs; i++) begin
            if (grants[i]) begin
                nx_lock[target_bank[i]] = 1'b1;
            end
        end

        // read transfers end on the bank side
        for (int b = 0; b < output_bus_pkg::num_banks; b++) begin
            if (bank_eos[b]) begin
                nx_lock[b] = 1'b0;
            end
        end

        // write transfers end on the writer's last beat
        for (int w = 0; w < output_bus_pkg::num_writers; w++) begin
            eos_bank = wr_node_id[w][output_bus_pkg::bank_w-1:0];
            if (wr_eos[w]) begin
                nx_lock[eos_bank] = 1'b0;
            end
        end

        for (int i = 0; i < output_bus_pkg::num_reqs; i++) begin
            req_bank = node_ids[i][output_bus_pkg::bank_w-1:0];
            masked_reqs[i] = reqs[i] & ~nx_lock[req_bank];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            lock <= '0;
        end else begin
            lock <= nx_lock;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < output_bus_pkg::num_reqs; i++) begin
            target_bank[i] <= node_ids[i][output_bus_pkg::bank_w-1:0];
        end
    end

endmodule

// ==== arbitration/rr_arbiter.sv ====
module rr_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic [output_bus_pkg::num_reqs-1:0] reqs,
    output logic [output_bus_pkg::num_reqs-1:0] grants
);

    // pointer kept as a thermometer, set bits are slots at or after it
    logic [output_bus_pkg::num_reqs-1:0] prio_mask;
    logic [output_bus_pkg::num_reqs-1:0] nx_prio_mask;
    logic [output_bus_pkg::num_reqs-1:0] hi_reqs;
    logic [output_bus_pkg::num_reqs-1:0] pick;

    assign hi_reqs = reqs & prio_mask;

    always_comb begin
        logic taken;
        logic above;

        taken = 1'b0;
        pick = '0;

        for (int i = 0; i < output_bus_pkg::num_reqs; i++) begin
            if (hi_reqs[i] && !taken) begin
                pick[i] = 1'b1;
                taken = 1'b1;
            end
        end

        // nothing at or after the pointer, wrap around from slot 0
        for (int i = 0; i < output_bus_pkg::num_reqs; i++) begin
            if (reqs[i] && !taken) begin
                pick[i] = 1'b1;
                taken = 1'b1;
            end
        end

        // next pointer sits just past the picked slot
        above = 1'b0;
        for (int i = 0; i < output_bus_pkg::num_reqs; i++) begin
            nx_prio_mask[i] = above;
            above = above | pick[i];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            grants <= '0;
            prio_mask <= '1;
        end else begin
            grants <= pick;
            if (|pick) begin
                prio_mask <= nx_prio_mask;
            end
        end
    end

endmodule

// ==== common/output_bus_pkg.sv ====
package output_bus_pkg;

    // requester slots, readers first then writers
    localparam int num_readers = 4;
    localparam int num_writers = 4;
    localparam int num_reqs = num_readers + num_writers;

    // output SRAM banks, picked by node id low bits
    localparam int num_banks = 4;
    localparam int bank_w = $clog2(num_banks);

    localparam int node_id_w = 10;
    localparam int pe_tag_w = 2;
    localparam int fv_w = 32;

    // write view sets the word width
    localparam int payload_w = fv_w + 2;

    // per-bank payload word, read view when rd_wr is 0, write view when 1
    typedef union packed {
        struct packed {
            logic [payload_w-pe_tag_w-1:0] pad;
            logic [pe_tag_w-1:0] pe_tag;
        } rd;
        struct packed {
            logic [fv_w-1:0] data;
            logic sos;
            logic eos;
        } wr;
    } bank_payload_t;

endpackage

// ==== rtl/bank_request_router.sv ====
module bank_request_router (
    input  logic clk,
    input  logic reset,
    input  logic [output_bus_pkg::num_readers-1:0] rd_grant_valid,
    input  logic [output_bus_pkg::pe_tag_w-1:0] rd_pe_tag [output_bus_pkg::num_readers],
    input  logic [output_bus_pkg::node_id_w-1:0] rd_node_id [output_bus_pkg::num_readers],
    input  logic [output_bus_pkg::num_writers-1:0] wr_grant_valid,
    input  logic [output_bus_pkg::num_writers-1:0] wr_sos,
    input  logic [output_bus_pkg::num_writers-1:0] wr_eos,
    input  logic [output_bus_pkg::fv_w-1:0] wr_data [output_bus_pkg::num_writers],
    input  logic [output_bus_pkg::node_id_w-1:0] wr_node_id [output_bus_pkg::num_writers],
    output logic [output_bus_pkg::num_banks-1:0] bank_valid,
    output logic [output_bus_pkg::num_banks-1:0] bank_rd_wr,
    output logic [output_bus_pkg::node_id_w-1:0] bank_node_id [output_bus_pkg::num_banks],
    output output_bus_pkg::bank_payload_t bank_payload [output_bus_pkg::num_banks]
);

    logic [output_bus_pkg::num_banks-1:0] nx_valid;
    logic [output_bus_pkg::num_banks-1:0] nx_rd_wr;
    logic [output_bus_pkg::node_id_w-1:0] nx_node_id [output_bus_pkg::num_banks];
    output_bus_pkg::bank_payload_t nx_payload [output_bus_pkg::num_banks];

    always_comb begin
        logic [output_bus_pkg::bank_w-1:0] sel;

        nx_valid = '0;
        nx_rd_wr = '0;
        for (int b = 0; b < output_bus_pkg::num_banks; b++) begin
            nx_node_id[b] = '0;
            nx_payload[b] = '0;
        end

        // reads first, so a writer beat on the same bank wins
        for (int r = 0; r < output_bus_pkg::num_readers; r++) begin
            sel = rd_node_id[r][output_bus_pkg::bank_w-1:0];
            if (rd_grant_valid[r]) begin
                nx_valid[sel] = 1'b1;
                nx_rd_wr[sel] = 1'b0;
                nx_node_id[sel] = rd_node_id[r];
                nx_payload[sel] = '0;
                nx_payload[sel].rd.pe_tag = rd_pe_tag[r];
            end
        end

        for (int w = 0; w < output_bus_pkg::num_writers; w++) begin
            sel = wr_node_id[w][output_bus_pkg::bank_w-1:0];
            if (wr_grant_valid[w]) begin
                nx_valid[sel] = 1'b1;
                nx_rd_wr[sel] = 1'b1;
                nx_node_id[sel] = wr_node_id[w];
                nx_payload[sel].wr.data = wr_data[w];
                nx_payload[sel].wr.sos = wr_sos[w];
                nx_payload[sel].wr.eos = wr_eos[w];
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bank_valid <= '0;
        end else begin
            bank_valid <= nx_valid;
        end
    end

    // word contents, zero in cycles with no beat
    always_ff @(posedge clk) begin
        bank_rd_wr <= nx_rd_wr;
        bank_node_id <= nx_node_id;
        bank_payload <= nx_payload;
    end

endmodule

// ==== rtl/output_bus_arbiter.sv ====
module output_bus_arbiter (
    input  logic clk,
    input  logic reset,

    // read requesters
    input  logic [output_bus_pkg::num_readers-1:0] rd_req,
    input  logic [output_bus_pkg::num_readers-1:0] rd_grant_valid,
    input  logic [output_bus_pkg::pe_tag_w-1:0] rd_pe_tag [output_bus_pkg::num_readers],
    input  logic [output_bus_pkg::node_id_w-1:0] rd_node_id [output_bus_pkg::num_readers],

    // write requesters
    input  logic [output_bus_pkg::num_writers-1:0] wr_req,
    input  logic [output_bus_pkg::num_writers-1:0] wr_grant_valid,
    input  logic [output_bus_pkg::num_writers-1:0] wr_sos,
    input  logic [output_bus_pkg::num_writers-1:0] wr_eos,
    input  logic [output_bus_pkg::fv_w-1:0] wr_data [output_bus_pkg::num_writers],
    input  logic [output_bus_pkg::node_id_w-1:0] wr_node_id [output_bus_pkg::num_writers],

    // end of read stream, one pulse per bank
    input  logic [output_bus_pkg::num_banks-1:0] bank_eos,

    output logic [output_bus_pkg::num_reqs-1:0] grants,
    output logic [output_bus_pkg::num_banks-1:0] bank_valid,
    output logic [output_bus_pkg::num_banks-1:0] bank_rd_wr,
    output logic [output_bus_pkg::node_id_w-1:0] bank_node_id [output_bus_pkg::num_banks],
    output output_bus_pkg::bank_payload_t bank_payload [output_bus_pkg::num_banks]
);

    logic [output_bus_pkg::num_reqs-1:0] reqs;
    logic [output_bus_pkg::num_reqs-1:0] masked_reqs;
    logic [output_bus_pkg::node_id_w-1:0] node_ids [output_bus_pkg::num_reqs];

    // slot order: readers 0..3, writers 4..7
    assign reqs = {wr_req, rd_req};

    always_comb begin
        for (int r = 0; r < output_bus_pkg::num_readers; r++) begin
            node_ids[r] = rd_node_id[r];
        end
        for (int w = 0; w < output_bus_pkg::num_writers; w++) begin
            node_ids[output_bus_pkg::num_readers + w] = wr_node_id[w];
        end
    end

    bank_lock_table u_lock_table (
        .clk         (clk),
        .reset       (reset),
        .reqs        (reqs),
        .node_ids    (node_ids),
        .grants      (grants),
        .wr_eos      (wr_eos),
        .wr_node_id  (wr_node_id),
        .bank_eos    (bank_eos),
        .masked_reqs (masked_reqs)
    );

    rr_arbiter u_rr_arbiter (
        .clk    (clk),
        .reset  (reset),
        .reqs   (masked_reqs),
        .grants (grants)
    );

    // routing runs beside arbitration on the same requester inputs
    bank_request_router u_router (
        .clk            (clk),
        .reset          (reset),
        .rd_grant_valid (rd_grant_valid),
        .rd_pe_tag      (rd_pe_tag),
        .rd_node_id     (rd_node_id),
        .wr_grant_valid (wr_grant_valid),
        .wr_sos         (wr_sos),
        .wr_eos         (wr_eos),
        .wr_data        (wr_data),
        .wr_node_id     (wr_node_id),
        .bank_valid     (bank_valid),
        .bank_rd_wr     (bank_rd_wr),
        .bank_node_id   (bank_node_id),
        .bank_payload   (bank_payload)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the output bus arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f src.f --top-module tb_output_bus_arbiter \
        --Mdir obj_dir -o sim_tb; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// ==== src.f ====
common/output_bus_pkg.sv
arbitration/bank_lock_table.sv
arbitration/rr_arbiter.sv
rtl/bank_request_router.sv
rtl/output_bus_arbiter.sv
testbench/tb_bus_model.sv
testbench/tb_output_bus_arbiter.sv

// ==== testbench/tb_bus_model.sv ====
module tb_bus_model (
    input  logic clk,
    input  logic reset,
    input  logic [3:0] rd_req,
    input  logic [3:0] rd_grant_valid,
    input  logic [1:0] rd_pe_tag [4],
    input  logic [9:0] rd_node_id [4],
    input  logic [3:0] wr_req,
    input  logic [3:0] wr_grant_valid,
    input  logic [3:0] wr_sos,
    input  logic [3:0] wr_eos,
    input  logic [31:0] wr_data [4],
    input  logic [9:0] wr_node_id [4],
    input  logic [3:0] bank_eos,
    output logic [7:0] exp_grants,
    output logic [3:0] exp_valid,
    output logic [3:0] exp_rd_wr,
    output logic [9:0] exp_node_id [4],
    output output_bus_pkg::bank_payload_t exp_payload [4],
    output logic [3:0] lock,
    output logic [3:0] rd_lock
);
    timeunit 1ns;
    timeprecision 100ps;

    // bank seen by each slot in the previous cycle
    logic [1:0] slot_bank [8];
    int ptr;

    always @(posedge clk or negedge reset) begin : step
        logic [3:0] nlock;
        logic [3:0] nrd;
        logic [7:0] reqs;
        logic [7:0] pick;
        logic [9:0] ids [8];
        logic found;
        int s;
        int nptr;
        if (!reset) begin
            exp_grants <= '0;
            exp_valid <= '0;
            exp_rd_wr <= '0;
            lock <= '0;
            rd_lock <= '0;
            ptr <= 0;
            for (int i = 0; i < 8; i++) slot_bank[i] <= '0;
            for (int b = 0; b < 4; b++) begin
                exp_node_id[b] <= '0;
                exp_payload[b] <= '0;
            end
        end else begin
            reqs = {wr_req, rd_req};
            for (int i = 0; i < 4; i++) begin
                ids[i] = rd_node_id[i];
                ids[i + 4] = wr_node_id[i];
            end
            nlock = lock;
            nrd = rd_lock;
            for (int i = 0; i < 8; i++) begin
                if (exp_grants[i]) begin
                    nlock[slot_bank[i]] = 1'b1;
                    nrd[slot_bank[i]] = (i < 4);
                end
            end
            // a clear beats a set in the same cycle
            for (int b = 0; b < 4; b++) if (bank_eos[b]) nlock[b] = 1'b0;
            for (int w = 0; w < 4; w++) if (wr_eos[w]) nlock[wr_node_id[w][1:0]] = 1'b0;
            pick = '0;
            found = 1'b0;
            nptr = ptr;
            for (int k = 0; k < 8; k++) begin
                s = (ptr + k) % 8;
                if (!found && reqs[s] && !nlock[ids[s][1:0]]) begin
                    pick[s] = 1'b1;
                    found = 1'b1;
                    nptr = (s + 1) % 8;
                end
            end
            exp_grants <= pick;
            ptr <= nptr;
            lock <= nlock;
            rd_lock <= nrd & nlock;
            for (int i = 0; i < 8; i++) slot_bank[i] <= ids[i][1:0];
            for (int b = 0; b < 4; b++) begin
                exp_valid[b] <= 1'b0;
                exp_rd_wr[b] <= 1'b0;
                exp_node_id[b] <= '0;
                exp_payload[b] <= '0;
            end
            // writers after readers, higher slot wins a shared bank
            for (int r = 0; r < 4; r++) begin
                if (rd_grant_valid[r]) begin
                    exp_valid[rd_node_id[r][1:0]] <= 1'b1;
                    exp_rd_wr[rd_node_id[r][1:0]] <= 1'b0;
                    exp_node_id[rd_node_id[r][1:0]] <= rd_node_id[r];
                    exp_payload[rd_node_id[r][1:0]] <= {32'h0, rd_pe_tag[r]};
                end
            end
            for (int w = 0; w < 4; w++) begin
                if (wr_grant_valid[w]) begin
                    exp_valid[wr_node_id[w][1:0]] <= 1'b1;
                    exp_rd_wr[wr_node_id[w][1:0]] <= 1'b1;
                    exp_node_id[wr_node_id[w][1:0]] <= wr_node_id[w];
                    exp_payload[wr_node_id[w][1:0]] <= {wr_data[w], wr_sos[w], wr_eos[w]};
                end
            end
        end
    end

endmodule

// ==== testbench/tb_output_bus_arbiter.sv ====
module tb_output_bus_arbiter;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int xfers_per_agent = 20;
    localparam int grant_timeout = 2000;
    localparam int run_timeout = 50000;

    logic clk;
    logic reset;
    logic [3:0] rd_req;
    logic [3:0] rd_grant_valid;
    logic [3:0] wr_req;
    logic [3:0] wr_grant_valid;
    logic [3:0] wr_sos;
    logic [3:0] wr_eos;
    logic [3:0] bank_eos;
    logic [1:0] rd_pe_tag [4];
    logic [9:0] rd_node_id [4];
    logic [31:0] wr_data [4];
    logic [9:0] wr_node_id [4];
    logic [7:0] grants;
    logic [7:0] exp_grants;
    logic [3:0] bank_valid;
    logic [3:0] bank_rd_wr;
    logic [3:0] exp_valid;
    logic [3:0] exp_rd_wr;
    logic [3:0] m_lock;
    logic [3:0] m_rd_lock;
    logic [9:0] bank_node_id [4];
    logic [9:0] exp_node_id [4];
    output_bus_pkg::bank_payload_t bank_payload [4];
    output_bus_pkg::bank_payload_t exp_payload [4];

    // agent state goes idle (0), requesting (1), granted (2), gap (3) and beats (4)
    int state [8];
    int count [8];
    int beats_left [8];
    int done_xfers [8];
    logic [3:0] pending_eos;
    logic [31:0] rng;

    output_bus_arbiter DUT (.*);

    tb_bus_model model (.*, .lock(m_lock), .rd_lock(m_rd_lock));

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        assert ($onehot0(grants)) else begin
            $display("grants has more than one bit set: 0x%h", grants);
            $display("Simulation failed");
            $fatal(1);
        end
        check_value("grants", 64'(grants), 64'(exp_grants));
        check_value("lock", 64'(DUT.u_lock_table.lock), 64'(m_lock));
        check_value("bank_valid", 64'(bank_valid), 64'(exp_valid));
        for (int b = 0; b < 4; b++) begin
            if (exp_valid[b]) begin
                check_value($sformatf("bank_rd_wr[%0d]", b), 64'(bank_rd_wr[b]),
                    64'(exp_rd_wr[b]));
                check_value($sformatf("bank_node_id[%0d]", b), 64'(bank_node_id[b]),
                    64'(exp_node_id[b]));
                if (exp_rd_wr[b]) begin
                    check_value($sformatf("bank_payload[%0d].wr", b), 64'(bank_payload[b].wr),
                        64'(exp_payload[b].wr));
                end else begin
                    check_value($sformatf("bank_payload[%0d].rd", b), 64'(bank_payload[b].rd),
                        64'(exp_payload[b].rd));
                end
            end
        end
    endtask

    // every requester agent steps once before the bank side is driven
    task automatic step_agents();
        for (int s = 0; s < 8; s++) begin
            if (s < 4) rd_grant_valid[s] = 1'b0;
            else begin
                wr_grant_valid[s - 4] = 1'b0;
                wr_sos[s - 4] = 1'b0;
                wr_eos[s - 4] = 1'b0;
            end
            case (state[s])
                0: begin
                    if (count[s] > 0) count[s]--;
                    else if (done_xfers[s] < xfers_per_agent) begin
                        if (s < 4) begin
                            rd_node_id[s] = 10'(next_rand());
                            rd_req[s] = 1'b1;
                        end else begin
                            wr_node_id[s - 4] = 10'(next_rand());
                            wr_req[s - 4] = 1'b1;
                        end
                        count[s] = 0;
                        state[s] = 1;
                    end
                end
                1: begin
                    if (grants[s]) state[s] = 2;
                    else begin
                        count[s]++;
                        if (count[s] > grant_timeout) begin
                            $display("slot %0d never got a grant", s);
                            $display("Simulation failed");
                            $fatal(1);
                        end
                    end
                end
                2: begin
                    if (s < 4) rd_req[s] = 1'b0;
                    else wr_req[s - 4] = 1'b0;
                    count[s] = next_rand() % 3;
                    beats_left[s] = (s < 4) ? 1 : 1 + next_rand() % 3;
                    state[s] = 3;
                end
                3: begin
                    if (count[s] > 0) count[s]--;
                    else state[s] = 4;
                end
                default: ;
            endcase
            if (state[s] == 4) begin
                if (s < 4) begin
                    rd_grant_valid[s] = 1'b1;
                    rd_pe_tag[s] = 2'(next_rand());
                    pending_eos[rd_node_id[s][1:0]] = 1'b1;
                end else begin
                    wr_grant_valid[s - 4] = 1'b1;
                    wr_data[s - 4] = next_rand();
                    wr_sos[s - 4] = (count[s] == 0);
                    wr_eos[s - 4] = (beats_left[s] == 1);
                    count[s] = 1;
                end
                beats_left[s]--;
                if (beats_left[s] == 0) begin
                    done_xfers[s]++;
                    count[s] = next_rand() % 8;
                    state[s] = 0;
                end
            end
        end
        // read ends only on banks that hold a finished read
        for (int b = 0; b < 4; b++) begin
            bank_eos[b] = 1'b0;
            if (pending_eos[b] && m_rd_lock[b] && next_rand() % 4 == 0) begin
                bank_eos[b] = 1'b1;
                pending_eos[b] = 1'b0;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        forever begin
            @(negedge clk);
            if (reset) compare_outputs();
        end
    end

    initial begin : main
        int waited;
        int total;
        reset = 1'b0;
        rng = 32'he846;
        {rd_req, rd_grant_valid, wr_req, wr_grant_valid, wr_sos, wr_eos, bank_eos} = '0;
        pending_eos = '0;
        for (int i = 0; i < 4; i++) begin
            rd_pe_tag[i] = '0;
            rd_node_id[i] = '0;
            wr_data[i] = '0;
            wr_node_id[i] = '0;
        end
        for (int s = 0; s < 8; s++) begin
            state[s] = 0;
            count[s] = 3 + s;
            beats_left[s] = 0;
            done_xfers[s] = 0;
        end
        repeat (10) @(posedge clk);
        #1 reset = 1'b1;
        waited = 0;
        total = 0;
        while (total < 8 * xfers_per_agent && waited < run_timeout) begin
            @(posedge clk);
            #1;
            step_agents();
            waited++;
            total = 0;
            for (int s = 0; s < 8; s++) total += done_xfers[s];
        end
        repeat (20) @(posedge clk);
        if (total < 8 * xfers_per_agent) begin
            $display("run timed out with %0d transfers done", total);
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
